//--- hw/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Execute back end sizing

`define CPU_LANES   4   // ALU lanes in rotation

// Result FIFO entries per lane, also the initial lane credits
`define LANE_DEPTH  2

// Input buffer entries, also the producer credits after reset
`define IN_DEPTH    4

`define OUT_CREDITS 4   // Consumer credits after reset

`define TAG_W       8   // Sequence tag width

`endif

//--- hw/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7   // Signed compare
} alu_op_e;

// Register-register form
typedef struct packed {
    logic        fmt;    // 0
    alu_op_e     op;
    logic [27:0] rsvd;
} instr_r_t;

// Register-immediate form
typedef struct packed {
    logic        fmt;    // 1
    alu_op_e     op;
    logic [11:0] rsvd;
    logic [15:0] imm;    // Sign-extended on issue
} instr_i_t;

// Format bit sits at bit 31 in both views
typedef union packed {
    instr_r_t r;
    instr_i_t i;
} instr_u;

typedef struct packed {
    instr_u      instr;
    logic [31:0] ra;
    logic [31:0] rb;
} in_instr_t;

typedef struct packed {
    alu_op_e           op;
    logic [31:0]       op1;
    logic [31:0]       op2;
    logic [`TAG_W-1:0] tag;
} issue_op_t;

typedef struct packed {
    logic [`TAG_W-1:0] tag;
    logic [31:0]       data;
} result_t;

endpackage

`default_nettype wire

//--- hw/issue_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module issue_dispatch (
    input  wire logic                  cpu_clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  in_valid_i,
    input  wire cpu_pkg::in_instr_t    in_instr_i,
    output logic                       in_credit_o,
    input  wire logic [`CPU_LANES-1:0] lane_credit_i,
    output logic [`CPU_LANES-1:0]      issue_valid_o,
    output cpu_pkg::issue_op_t         issue_op_o
);

localparam int IN_PTR_W = $clog2(`IN_DEPTH);
localparam int IN_CNT_W = $clog2(`IN_DEPTH + 1);
localparam int LANE_W   = $clog2(`CPU_LANES);
localparam int CRED_W   = $clog2(`LANE_DEPTH + 1);

cpu_pkg::in_instr_t  in_mem [`IN_DEPTH];
logic [IN_PTR_W-1:0] wr_ptr_q;
logic [IN_PTR_W-1:0] rd_ptr_q;
logic [IN_CNT_W-1:0] in_cnt_q;
logic [LANE_W-1:0]   lane_ptr_q;
logic [`TAG_W-1:0]   tag_q;
logic [CRED_W-1:0]   lane_cred_q [`CPU_LANES];

cpu_pkg::in_instr_t  head;
cpu_pkg::alu_op_e    head_op;
logic [31:0]         head_op2;
logic                pop;

assign head = in_mem[rd_ptr_q];

// Never skip a lane, wait for its credit instead
assign pop = (in_cnt_q != '0) && (lane_cred_q[lane_ptr_q] != '0);

always_comb begin
    head_op = head.instr.r.op;   // Same field position in both views
    if (head.instr.r.fmt == 1'b0) begin
        head_op2 = head.rb;
    end else begin
        head_op2 = {{16{head.instr.i.imm[15]}}, head.instr.i.imm};
    end
end

always_ff @(posedge cpu_clk_i) begin
    if (in_valid_i) begin
        in_mem[wr_ptr_q] <= in_instr_i;
    end
end

always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wr_ptr_q    <= '0;
        rd_ptr_q    <= '0;
        in_cnt_q    <= '0;
        in_credit_o <= 1'b0;
    end else begin
        in_credit_o <= pop;   // One credit back per pop
        if (in_valid_i) begin
            wr_ptr_q <= (wr_ptr_q == IN_PTR_W'(`IN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
            rd_ptr_q <= (rd_ptr_q == IN_PTR_W'(`IN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        in_cnt_q <= in_cnt_q + IN_CNT_W'(in_valid_i) - IN_CNT_W'(pop);
    end
end

always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        issue_valid_o <= '0;
        lane_ptr_q    <= '0;
        tag_q         <= '0;
    end else begin
        issue_valid_o <= '0;
        if (pop) begin
            issue_valid_o[lane_ptr_q] <= 1'b1;
            lane_ptr_q <= (lane_ptr_q == LANE_W'(`CPU_LANES - 1)) ? '0 : lane_ptr_q + 1'b1;
            tag_q      <= tag_q + 1'b1;
        end
    end
end

always_ff @(posedge cpu_clk_i) begin
    if (pop) begin
        issue_op_o.op  <= head_op;
        issue_op_o.op1 <= head.ra;
        issue_op_o.op2 <= head_op2;
        issue_op_o.tag <= tag_q;
    end
end

// Spent at pop, returned when the collector drains the lane
always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        for (int k = 0; k < `CPU_LANES; k++) begin
            lane_cred_q[k] <= CRED_W'(`LANE_DEPTH);
        end
    end else begin
        for (int k = 0; k < `CPU_LANES; k++) begin
            lane_cred_q[k] <= lane_cred_q[k] + CRED_W'(lane_credit_i[k])
                            - CRED_W'(pop && (lane_ptr_q == LANE_W'(k)));
        end
    end
end

assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
    in_valid_i |-> (in_cnt_q != IN_CNT_W'(`IN_DEPTH)))
    else $error("input written while buffer full");

for (genvar g = 0; g < `CPU_LANES; g++) begin : g_cred_chk
    assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        lane_cred_q[g] <= CRED_W'(`LANE_DEPTH))
        else $error("lane %0d credit count overflow", g);
end

endmodule

`default_nettype wire

//--- hw/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module alu_lane (
    input  wire logic               cpu_clk_i,
    input  wire logic               rst_n_i,
    input  wire logic               push_i,
    input  wire cpu_pkg::issue_op_t op_i,
    input  wire logic               pop_i,
    output logic                    head_valid_o,
    output cpu_pkg::result_t        head_o,
    output logic                    credit_o
);

localparam int PTR_W = (`LANE_DEPTH > 1) ? $clog2(`LANE_DEPTH) : 1;
localparam int CNT_W = $clog2(`LANE_DEPTH + 1);

cpu_pkg::result_t fifo_mem [`LANE_DEPTH];
logic [PTR_W-1:0] wr_ptr_q;
logic [PTR_W-1:0] rd_ptr_q;
logic [CNT_W-1:0] cnt_q;
logic [31:0]      alu_res;
logic [4:0]       shamt;

assign shamt = op_i.op2[4:0];   // Low 5 bits only

always_comb begin
    case (op_i.op)
        cpu_pkg::ALU_ADD: alu_res = op_i.op1 + op_i.op2;
        cpu_pkg::ALU_SUB: alu_res = op_i.op1 - op_i.op2;
        cpu_pkg::ALU_AND: alu_res = op_i.op1 & op_i.op2;
        cpu_pkg::ALU_OR:  alu_res = op_i.op1 | op_i.op2;
        cpu_pkg::ALU_XOR: alu_res = op_i.op1 ^ op_i.op2;
        cpu_pkg::ALU_SLL: alu_res = op_i.op1 << shamt;
        cpu_pkg::ALU_SRL: alu_res = op_i.op1 >> shamt;
        cpu_pkg::ALU_SLT: alu_res = {31'b0, $signed(op_i.op1) < $signed(op_i.op2)};
        default:          alu_res = '0;
    endcase
end

always_ff @(posedge cpu_clk_i) begin
    if (push_i) begin
        fifo_mem[wr_ptr_q].tag  <= op_i.tag;
        fifo_mem[wr_ptr_q].data <= alu_res;
    end
end

always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
        credit_o <= 1'b0;
    end else begin
        credit_o <= pop_i;
        if (push_i) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(`LANE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop_i) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(`LANE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop_i);
    end
end

assign head_valid_o = (cnt_q != '0);
assign head_o       = fifo_mem[rd_ptr_q];

// Dispatcher credits must keep the FIFO from overflowing
assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
    push_i |-> (cnt_q != CNT_W'(`LANE_DEPTH)))
    else $error("push into full lane FIFO");

assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
    pop_i |-> head_valid_o)
    else $error("pop from empty lane FIFO");

endmodule

`default_nettype wire

//--- hw/result_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module result_collect (
    input  wire logic                               cpu_clk_i,
    input  wire logic                               rst_n_i,
    input  wire logic [`CPU_LANES-1:0]              head_valid_i,
    input  wire cpu_pkg::result_t [`CPU_LANES-1:0]  head_i,
    output logic [`CPU_LANES-1:0]                   pop_o,
    output logic                                    out_valid_o,
    output cpu_pkg::result_t                        out_result_o,
    input  wire logic                               out_credit_i
);

localparam int LANE_W = $clog2(`CPU_LANES);
localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

logic [LANE_W-1:0] ptr_q;   // Follows dispatch order
logic [CRED_W-1:0] cred_q;
logic              take;

// Wait on the current lane even if others have results
assign take = head_valid_i[ptr_q] && (cred_q != '0);

always_comb begin
    pop_o        = '0;
    pop_o[ptr_q] = take;
end

always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ptr_q       <= '0;
        cred_q      <= CRED_W'(`OUT_CREDITS);
        out_valid_o <= 1'b0;
    end else begin
        out_valid_o <= take;
        if (take) begin
            ptr_q <= (ptr_q == LANE_W'(`CPU_LANES - 1)) ? '0 : ptr_q + 1'b1;
        end
        // Credit is spent at the pop, one cycle ahead of out_valid_o
        cred_q <= cred_q - CRED_W'(take) + CRED_W'(out_credit_i);
    end
end

always_ff @(posedge cpu_clk_i) begin
    if (take) begin
        out_result_o <= head_i[ptr_q];
    end
end

// Consumer returns no more credits than it was given
assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
    cred_q <= CRED_W'(`OUT_CREDITS))
    else $error("output credit count overflow");

endmodule

`default_nettype wire

//--- hw/execute_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module execute_top (
    input  wire logic               cpu_clk_i,
    input  wire logic               rst_n_i,
    input  wire logic               in_valid_i,
    input  wire cpu_pkg::in_instr_t in_instr_i,
    output logic                    in_credit_o,
    output logic                    out_valid_o,
    output cpu_pkg::result_t        out_result_o,
    input  wire logic               out_credit_i
);

logic [`CPU_LANES-1:0]             lane_issue_valid;
cpu_pkg::issue_op_t                issue_op;   // Shared by all lanes
logic [`CPU_LANES-1:0]             lane_credit;
logic [`CPU_LANES-1:0]             lane_head_valid;
cpu_pkg::result_t [`CPU_LANES-1:0] lane_head;
logic [`CPU_LANES-1:0]             lane_pop;

issue_dispatch issue_dispatch (
    .cpu_clk_i     (cpu_clk_i),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_instr_i    (in_instr_i),
    .in_credit_o   (in_credit_o),
    .lane_credit_i (lane_credit),
    .issue_valid_o (lane_issue_valid),
    .issue_op_o    (issue_op)
);

for (genvar g = 0; g < `CPU_LANES; g++) begin : g_lane
    alu_lane alu_lane (
        .cpu_clk_i    (cpu_clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (lane_issue_valid[g]),
        .op_i         (issue_op),
        .pop_i        (lane_pop[g]),
        .head_valid_o (lane_head_valid[g]),
        .head_o       (lane_head[g]),
        .credit_o     (lane_credit[g])
    );
end

result_collect result_collect (
    .cpu_clk_i    (cpu_clk_i),
    .rst_n_i      (rst_n_i),
    .head_valid_i (lane_head_valid),
    .head_i       (lane_head),
    .pop_o        (lane_pop),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_credit_i (out_credit_i)
);

endmodule

`default_nettype wire

//--- testbench/tb_execute_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_execute_top;

localparam int NUM_INSTR       = 86;   // All instructions over all tests
localparam int WATCHDOG_CYCLES = NUM_INSTR * 20 + 2000;

logic               cpu_clk_i;
logic               rst_n_i;
logic               in_valid_i;
cpu_pkg::in_instr_t in_instr_i;
logic               in_credit_o;
logic               out_valid_o;
cpu_pkg::result_t   out_result_o;
logic               out_credit_i;

cpu_pkg::in_instr_t send_q [$];   // Waiting for input credit
cpu_pkg::result_t   exp_q [$];    // Reference results in program order

int          in_cred     = `IN_DEPTH;
int          cred_pulses = 0;
int          sent_cnt    = 0;
int          rx_cnt      = 0;
int          owed        = 0;     // Output credits not yet returned
int          tag_cnt     = 0;
int          err_cnt     = 0;
int          chk_cnt     = 0;
bit          return_en   = 1'b1;
logic [31:0] lcg_state   = 32'd39420;

execute_top UUT (
    .cpu_clk_i    (cpu_clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_instr_i   (in_instr_i),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_credit_i (out_credit_i)
);

initial begin
    cpu_clk_i = 1'b0;
    forever #2 cpu_clk_i = ~cpu_clk_i;
end

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Opcode rules, op2 already resolved
function automatic logic [31:0] expected_data(cpu_pkg::alu_op_e op, logic [31:0] a,
                                              logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        cpu_pkg::ALU_ADD: return a + b;
        cpu_pkg::ALU_SUB: return a - b;
        cpu_pkg::ALU_AND: return a & b;
        cpu_pkg::ALU_OR:  return a | b;
        cpu_pkg::ALU_XOR: return a ^ b;
        cpu_pkg::ALU_SLL: return a << sh;
        cpu_pkg::ALU_SRL: return a >> sh;
        default: begin
            if (a[31] != b[31]) return {31'b0, a[31]};   // Negative one is smaller
            return {31'b0, a < b};
        end
    endcase
endfunction

task automatic check_result(input cpu_pkg::result_t got, input cpu_pkg::result_t exp);
    chk_cnt++;
    if (got.tag !== exp.tag) begin
        $display("[FAIL] out_result_o.tag got 0x%h expected 0x%h", got.tag, exp.tag);
        err_cnt++;
    end
    if (got.data !== exp.data) begin
        $display("[FAIL] out_result_o.data got 0x%h expected 0x%h (tag 0x%h)",
                 got.data, exp.data, exp.tag);
        err_cnt++;
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        err_cnt++;
    end
endtask

task automatic queue_instr(input logic imm_fmt, input cpu_pkg::alu_op_e op,
                           input logic [31:0] ra, input logic [31:0] rb,
                           input logic [15:0] imm);
    cpu_pkg::in_instr_t word;
    cpu_pkg::result_t   exp;
    logic [31:0]        op2;
    word = '0;
    if (imm_fmt) begin
        word.instr.i.fmt = 1'b1;
        word.instr.i.op  = op;
        word.instr.i.imm = imm;
        op2 = {{16{imm[15]}}, imm};
    end else begin
        word.instr.r.fmt = 1'b0;
        word.instr.r.op  = op;
        op2 = rb;
    end
    word.ra  = ra;
    word.rb  = rb;
    exp.tag  = `TAG_W'(tag_cnt);
    exp.data = expected_data(op, ra, op2);
    tag_cnt++;
    exp_q.push_back(exp);
    send_q.push_back(word);
endtask

task automatic drain_results();
    while (send_q.size() != 0 || exp_q.size() != 0) @(posedge cpu_clk_i);
endtask

// Producer obeys its input credits
always @(posedge cpu_clk_i) begin
    if (in_credit_o === 1'b1) begin
        in_cred++;
        cred_pulses++;
    end
    if (rst_n_i && send_q.size() != 0 && in_cred > 0) begin
        in_valid_i <= 1'b1;
        in_instr_i <= send_q.pop_front();
        in_cred--;
        sent_cnt++;
    end else begin
        in_valid_i <= 1'b0;
    end
end

// Consumer checks each result and returns its credit
always @(posedge cpu_clk_i) begin
    if (out_valid_o === 1'b1) begin
        rx_cnt++;
        owed++;
        if (exp_q.size() == 0) begin
            $display("Unexpected out_valid_o with no result outstanding at %0t", $time);
            err_cnt++;
        end else begin
            check_result(out_result_o, exp_q.pop_front());
        end
    end
    if (return_en && owed > 0) begin
        out_credit_i <= 1'b1;
        owed--;
    end else begin
        out_credit_i <= 1'b0;
    end
end

task automatic idle_after_reset();
    repeat (20) begin
        @(posedge cpu_clk_i);
        if (out_valid_o !== 1'b0 || in_credit_o !== 1'b0) begin
            $display("Output or input credit active while idle after reset at %0t", $time);
            err_cnt++;
        end
    end
endtask

task automatic reg_format_ops();
    for (int k = 0; k < 8; k++) begin
        queue_instr(1'b0, cpu_pkg::alu_op_e'(k), lcg_next(), lcg_next(), 16'h0);
    end
    queue_instr(1'b0, cpu_pkg::ALU_SLT, -32'sd5, -32'sd3, 16'h0);   // Both negative
    queue_instr(1'b0, cpu_pkg::ALU_SLT, -32'sd7, 32'd9, 16'h0);
    queue_instr(1'b0, cpu_pkg::ALU_SLL, lcg_next(), 32'd0, 16'h0);
    queue_instr(1'b0, cpu_pkg::ALU_SLL, lcg_next(), 32'd31, 16'h0);
    queue_instr(1'b0, cpu_pkg::ALU_SRL, 32'h8000_0001, 32'hFFFF_FFE0, 16'h0);   // Shift by 0
    queue_instr(1'b0, cpu_pkg::ALU_SRL, 32'h8000_0001, 32'd31, 16'h0);
    drain_results();
endtask

task automatic imm_format_ops();
    queue_instr(1'b1, cpu_pkg::ALU_ADD, lcg_next(), lcg_next(), 16'h7FFF);
    queue_instr(1'b1, cpu_pkg::ALU_ADD, lcg_next(), lcg_next(), 16'h8000);
    queue_instr(1'b1, cpu_pkg::ALU_SUB, lcg_next(), lcg_next(), 16'h8000);
    queue_instr(1'b1, cpu_pkg::ALU_SLT, 32'd0, lcg_next(), 16'h8000);
    drain_results();
endtask

task automatic ordered_burst(input int count);
    logic [31:0] r;
    for (int k = 0; k < count; k++) begin
        r = lcg_next();
        queue_instr(r[31], cpu_pkg::alu_op_e'(r[30:28]), lcg_next(), lcg_next(), r[15:0]);
    end
    drain_results();
endtask

task automatic output_backpressure();
    int base;
    while (owed != 0) @(posedge cpu_clk_i);
    return_en = 1'b0;
    base = rx_cnt;
    for (int k = 0; k < 20; k++) begin
        queue_instr(1'b0, cpu_pkg::ALU_XOR, lcg_next(), lcg_next(), 16'h0);
    end
    while ((rx_cnt - base) < `OUT_CREDITS) @(posedge cpu_clk_i);
    repeat (40) @(posedge cpu_clk_i);   // Long enough for the pipe to fill and stall
    check_count("results with no credit returned", rx_cnt - base, `OUT_CREDITS);
    check_count("producer credits at stall", in_cred, 0);
    check_count("instructions held back", send_q.size(), 20 - 16);
    return_en = 1'b1;
    drain_results();
endtask

task automatic input_credit_balance();
    int base_pulses;
    int base_sent;
    base_pulses = cred_pulses;
    base_sent   = sent_cnt;
    for (int k = 0; k < 8; k++) begin
        queue_instr(1'b0, cpu_pkg::ALU_ADD, lcg_next(), lcg_next(), 16'h0);
    end
    drain_results();
    check_count("in_credit_o pulses", cred_pulses - base_pulses, sent_cnt - base_sent);
    check_count("producer credits after drain", in_cred, `IN_DEPTH);
endtask

initial begin
    rst_n_i      = 1'b0;
    in_valid_i   = 1'b0;
    in_instr_i   = '0;
    out_credit_i = 1'b0;
    repeat (10) @(posedge cpu_clk_i);
    rst_n_i <= 1'b1;
    idle_after_reset();
    reg_format_ops();
    imm_format_ops();
    ordered_burst(40);
    output_backpressure();
    input_credit_balance();
    check_count("total results", rx_cnt, NUM_INSTR);
    $display("errors: %0d, results checked: %0d", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge cpu_clk_i);
    $display("Watchdog expired before all tests finished, errors so far: %0d", err_cnt);
    $display("TEST FAIL");
    $finish;
end

endmodule

`default_nettype wire

//--- execute_subsys.f
+incdir+hw
hw/cpu_pkg.sv
hw/issue_dispatch.sv
hw/alu_lane.sv
hw/result_collect.sv
hw/execute_top.sv
testbench/tb_execute_top.sv
